// ==== rename_pkg.sv ====
package rename_pkg;

   // ======================================
   // Register naming
   // ======================================

   localparam int AREGS = 8;  // Architectural registers visible to software

   typedef logic [2:0] aregno_t;  // Architectural register number
   typedef logic [4:0] pregno_t;  // Physical register number, 32 physical registers

   // One whole map, entry i holds the physical register behind architectural register i
   // Entry 0 sits in the low bits
   typedef pregno_t [AREGS-1:0] checkpoint_t;

   // ======================================
   // Map after reset
   // ======================================

   // Identity map so that architectural register i starts out in physical register i
   localparam checkpoint_t RESET_MAP = {
      5'd7, 5'd6, 5'd5, 5'd4,
      5'd3, 5'd2, 5'd1, 5'd0
   };

endpackage

// ==== ckpt_pkg.sv ====
package ckpt_pkg;

   // Index of one checkpoint slot in the snapshot RAM
   // Four bits cover up to 16 slots
   typedef logic [3:0] ckptno_t;

   // Number of live checkpoints
   // One bit wider than the index so a completely full queue can be told from an empty one
   typedef logic [4:0] ckcnt_t;

endpackage

// ==== ckpt_if.sv ====
interface ckpt_if;

   // Write side, a full snapshot of the map goes into one slot
   logic                    wr_en;    // Take a snapshot this cycle
   ckpt_pkg::ckptno_t       wr_addr;  // Slot that receives the snapshot
   rename_pkg::checkpoint_t wr_data;  // Map as it stands before this cycle's rename

   // Read side, used when a branch mispredicts
   ckpt_pkg::ckptno_t       rd_addr;  // Slot to restore from
   rename_pkg::checkpoint_t rd_data;  // Snapshot held in that slot

   // The rename table owns the addresses and the write data
   modport map_mp (
      output wr_en, wr_addr, wr_data, rd_addr,
      input  rd_data
   );

   // The RAM answers reads without a clock
   modport ram_mp (
      input  wr_en, wr_addr, wr_data, rd_addr,
      output rd_data
   );

endinterface

// ==== checkpoint_ram.sv ====
module checkpoint_ram #(
   parameter int NCHECK = 16  // Number of snapshot slots
) (
   input logic clka,
   input logic arst_n,
   ckpt_if.ram_mp ram
);

   // ======================================
   // Storage
   // ======================================

   rename_pkg::checkpoint_t mem [0:NCHECK-1];  // One map snapshot per slot

   logic                    wr_pend;    // A registered write waits for the next edge
   ckpt_pkg::ckptno_t       wr_addr_q;  // Slot of the waiting write
   rename_pkg::checkpoint_t wr_data_q;  // Snapshot of the waiting write

   // ======================================
   // Delayed write
   // ======================================

   // The request is captured at the edge that ends the save cycle
   // and lands in the array one edge later
   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         wr_pend <= 1'b0;  // Nothing waits after reset
      end else begin
         wr_pend <= ram.wr_en;
      end
   end

   // Address and data only matter while wr_pend is set
   always_ff @(posedge clka) begin
      wr_addr_q <= ram.wr_addr;
      wr_data_q <= ram.wr_data;
   end

   always_ff @(posedge clka) begin
      if (wr_pend) begin
         mem[wr_addr_q] <= wr_data_q;  // Second edge, the snapshot becomes readable
      end
   end

   // ======================================
   // Asynchronous read
   // ======================================

   assign ram.rd_data = mem[ram.rd_addr];  // Distributed style, no read latency

   // The allocator wraps at NCHECK, so the rename table must never hand over a slot past it
   a_wr_addr_range : assert property (
      @(posedge clka) disable iff (!arst_n)
      ram.wr_en |-> (int'(ram.wr_addr) < NCHECK)
   ) else $error("Snapshot write to slot %0d outside of %0d slots", ram.wr_addr, NCHECK);

endmodule

// ==== checkpoint_alloc.sv ====
module checkpoint_alloc #(
   parameter int NCHECK = 16  // Slots in the circular queue
) (
   input  logic              clka,
   input  logic              arst_n,
   input  logic              save,        // Allocate the slot at the tail
   input  logic              free,        // Release the oldest slot
   input  logic              restore,     // Roll back to restore_id
   input  ckpt_pkg::ckptno_t restore_id,  // Slot being restored
   output ckpt_pkg::ckptno_t ckpt_id,     // Slot the next save gets
   output logic              ckpt_full    // No slot left for a save
);

   ckpt_pkg::ckptno_t head, head_nxt;    // Oldest live checkpoint
   ckpt_pkg::ckptno_t tail, tail_nxt;    // Next slot to hand out
   ckpt_pkg::ckcnt_t  count, count_nxt;  // Live checkpoints between head and tail
   ckpt_pkg::ckcnt_t  restore_dist;      // Checkpoints older than the restored one

   // Step to the next slot, wrapping at NCHECK rather than at the index width
   function automatic ckpt_pkg::ckptno_t wrap_inc(input ckpt_pkg::ckptno_t x);
      return (int'(x) == NCHECK - 1) ? '0 : ckpt_pkg::ckptno_t'(x + 1'b1);
   endfunction

   // Distance from the head to the restored slot around the ring
   // Everything from restore_id onward is discarded, so this is what survives
   assign restore_dist = (restore_id >= head) ?
                         ckpt_pkg::ckcnt_t'(restore_id - head) :
                         ckpt_pkg::ckcnt_t'(restore_id) + ckpt_pkg::ckcnt_t'(NCHECK)
                         - ckpt_pkg::ckcnt_t'(head);

   // ======================================
   // Next state
   // ======================================

   always_comb begin
      head_nxt  = free ? wrap_inc(head) : head;  // Frees always come from the old end
      tail_nxt  = tail;
      count_nxt = count;
      if (restore) begin
         tail_nxt  = restore_id;  // The restored slot and all younger ones go back to the pool
         count_nxt = restore_dist - ckpt_pkg::ckcnt_t'(free);
      end else begin
         if (save) tail_nxt = wrap_inc(tail);
         count_nxt = count + ckpt_pkg::ckcnt_t'(save) - ckpt_pkg::ckcnt_t'(free);
      end
   end

   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;  // Queue starts empty
      end else begin
         head  <= head_nxt;
         tail  <= tail_nxt;
         count <= count_nxt;
      end
   end

   assign ckpt_id   = tail;
   assign ckpt_full = (count == ckpt_pkg::ckcnt_t'(NCHECK));  // Head and tail meet with all slots live

   // A save while full would overwrite the oldest live snapshot
   a_no_save_full : assert property (@(posedge clka) disable iff (!arst_n) save |-> !ckpt_full)
      else $error("Checkpoint save while all slots are in use");

   a_no_free_empty : assert property (@(posedge clka) disable iff (!arst_n) free |-> count != 0)
      else $error("Checkpoint free with no live checkpoint");

   // Only a slot that was handed out and not yet freed can be restored
   a_restore_live : assert property (
      @(posedge clka) disable iff (!arst_n) restore |-> (restore_dist < count)
   ) else $error("Restore of slot %0d that is not live", restore_id);

endmodule

// ==== rename_map.sv ====
module rename_map (
   input  logic                clka,
   input  logic                arst_n,
   input  logic                ren_valid,   // Rename one destination this cycle
   input  rename_pkg::aregno_t ren_dst,     // Destination being renamed
   input  rename_pkg::pregno_t ren_newp,    // Physical register supplied by the caller
   input  rename_pkg::aregno_t src_areg,    // Source to look up
   input  logic                save,        // Snapshot the map at a branch
   input  ckpt_pkg::ckptno_t   save_id,     // Slot for the snapshot
   input  logic                restore,     // Reload the map after a mispredict
   input  ckpt_pkg::ckptno_t   restore_id,  // Slot to reload from
   output rename_pkg::pregno_t src_preg,    // Current mapping of src_areg
   output rename_pkg::pregno_t old_preg,    // Mapping that ren_dst had before the rename
   ckpt_if.map_mp              ram
);

   // ======================================
   // Live table
   // ======================================

   rename_pkg::checkpoint_t map_q;  // Current architectural to physical mapping

   // Lookups see the table as it stands at the start of the cycle
   // so a rename only shows up one cycle later
   assign src_preg = map_q[src_areg];
   assign old_preg = map_q[ren_dst];  // Caller frees this one when the renaming instruction retires

   always_ff @(posedge clka or negedge arst_n) begin
      if (!arst_n) begin
         map_q <= rename_pkg::RESET_MAP;  // Identity map
      end else if (restore) begin
         map_q <= ram.rd_data;  // Whole map comes back in one edge
      end else if (ren_valid) begin
         map_q[ren_dst] <= ren_newp;  // Only one entry changes per cycle
      end
   end

   // ======================================
   // Snapshot traffic
   // ======================================

   // The register still holds the pre-rename map during the save cycle
   // so the snapshot excludes this cycle's rename
   assign ram.wr_en   = save;
   assign ram.wr_addr = save_id;
   assign ram.wr_data = map_q;

   // Read address follows restore_id without a register
   // because the RAM read is asynchronous
   assign ram.rd_addr = restore_id;

   // A rename or save beside a restore would be lost or would snapshot a dead path
   a_restore_alone : assert property (
      @(posedge clka) disable iff (!arst_n) restore |-> !(ren_valid || save)
   ) else $error("Rename or save issued in a restore cycle");

endmodule

// ==== rename_top.sv ====
module rename_top #(
   parameter int NCHECK = 16  // Checkpoint slots, 2 to 16
) (
   input  logic                clka,
   input  logic                arst_n,
   input  logic                ren_valid,   // Rename strobe
   input  rename_pkg::aregno_t ren_dst,     // Destination architectural register
   input  rename_pkg::pregno_t ren_newp,    // New physical register
   input  rename_pkg::aregno_t src_areg,    // Source to look up
   input  logic                ckpt_save,   // Take a checkpoint at a branch
   input  logic                ckpt_free,   // Oldest branch resolved correctly
   input  logic                restore,     // Branch mispredicted
   input  ckpt_pkg::ckptno_t   restore_id,  // Checkpoint of the mispredicted branch
   output rename_pkg::pregno_t src_preg,    // Mapping of src_areg
   output rename_pkg::pregno_t old_preg,    // Previous mapping of ren_dst
   output ckpt_pkg::ckptno_t   ckpt_id,     // Checkpoint the next save gets
   output logic                ckpt_full    // No checkpoint slot left
);

   ckpt_if ram_if ();  // Snapshot path between table and RAM

   // ======================================
   // Blocks
   // ======================================

   checkpoint_alloc #(.NCHECK(NCHECK)) u_alloc (
      .clka       (clka),
      .arst_n     (arst_n),
      .save       (ckpt_save),
      .free       (ckpt_free),
      .restore    (restore),
      .restore_id (restore_id),
      .ckpt_id    (ckpt_id),
      .ckpt_full  (ckpt_full)
   );

   // The slot the allocator offers this cycle is the one the snapshot goes to
   rename_map u_map (
      .clka       (clka),
      .arst_n     (arst_n),
      .ren_valid  (ren_valid),
      .ren_dst    (ren_dst),
      .ren_newp   (ren_newp),
      .src_areg   (src_areg),
      .save       (ckpt_save),
      .save_id    (ckpt_id),
      .restore    (restore),
      .restore_id (restore_id),
      .src_preg   (src_preg),
      .old_preg   (old_preg),
      .ram        (ram_if.map_mp)
   );

   checkpoint_ram #(.NCHECK(NCHECK)) u_ram (
      .clka   (clka),
      .arst_n (arst_n),
      .ram    (ram_if.ram_mp)
   );

endmodule

// ==== tb_rename.sv ====
module tb_rename;

   // ======================================
   // Settings of the run
   // ======================================

   localparam int NCHECK   = 16;  // Checkpoint slots in the DUT
   localparam int NFIELDS  = 12;  // Tokens on one stimulus line
   localparam int MAXLINES = 64;  // Room for this many vectors
   localparam int RST_WAIT = 20;  // Cycles allowed before reset must be gone

   logic                clka;
   logic                arst_n;
   logic                ren_valid;
   rename_pkg::aregno_t ren_dst;
   rename_pkg::pregno_t ren_newp;
   rename_pkg::aregno_t src_areg;
   logic                ckpt_save;
   logic                ckpt_free;
   logic                restore;
   ckpt_pkg::ckptno_t   restore_id;
   rename_pkg::pregno_t src_preg;
   rename_pkg::pregno_t old_preg;
   ckpt_pkg::ckptno_t   ckpt_id;
   logic                ckpt_full;

   logic [7:0] stim [0:NFIELDS*MAXLINES-1];  // Flat copy of the stimulus file
   int         nlines;                       // Vectors found in the file

   rename_top #(.NCHECK(NCHECK)) dut_i (
      .clka       (clka),
      .arst_n     (arst_n),
      .ren_valid  (ren_valid),
      .ren_dst    (ren_dst),
      .ren_newp   (ren_newp),
      .src_areg   (src_areg),
      .ckpt_save  (ckpt_save),
      .ckpt_free  (ckpt_free),
      .restore    (restore),
      .restore_id (restore_id),
      .src_preg   (src_preg),
      .old_preg   (old_preg),
      .ckpt_id    (ckpt_id),
      .ckpt_full  (ckpt_full)
   );

   always #10 clka = ~clka;  // Period of 20

   // Reset covers three rising edges and lets go on a falling edge
   initial begin
      clka   = 1'b0;
      arst_n = 1'b0;
      repeat (3) @(posedge clka);
      @(negedge clka);
      arst_n = 1'b1;
   end

   // ======================================
   // Failure handling
   // ======================================

   task automatic stop_run();
      $display("Test failed");
      $fatal(1, "Simulation stopped after an error");
   endtask

   // Anything that is not a wrong value lands here with a plain description
   task automatic abort_run(input string what);
      $display("%s", what);
      stop_run();
   endtask

   task automatic check_value(input string name, input int vec, input logic [7:0] actual,
                              input logic [7:0] expected);
      if (actual !== expected) begin
         $display("[FAIL] vector %0d %s: got 0x%0h, expected 0x%0h",
                  vec, name, actual, expected);
         stop_run();
      end
   endtask

   // ======================================
   // Stimulus and checks
   // ======================================

   initial begin
      int line;
      int base;
      int waited;
      ren_valid  = 1'b0;  // Idle inputs change nothing in the DUT
      ren_dst    = '0;
      ren_newp   = '0;
      src_areg   = '0;
      ckpt_save  = 1'b0;
      ckpt_free  = 1'b0;
      restore    = 1'b0;
      restore_id = '0;

      for (int i = 0; i < NFIELDS * MAXLINES; i++) begin
         stim[i] = 8'hff;  // A first token of ff marks the end of the vectors
      end
      $readmemh("rename_stimulus.txt", stim);
      nlines = 0;
      while (nlines < MAXLINES && stim[nlines*NFIELDS] != 8'hff) nlines++;
      if (nlines == 0) abort_run("Stimulus file rename_stimulus.txt holds no vectors");

      waited = 0;
      while (arst_n !== 1'b1 && waited < RST_WAIT) begin
         waited++;
         @(posedge clka);
      end
      if (arst_n !== 1'b1) abort_run("Reset was not released in time");

      for (line = 0; line < nlines; line++) begin
         base = line * NFIELDS;
         @(negedge clka);  // Inputs change half a period away from the active edge
         ren_valid  = stim[base][0];
         ren_dst    = stim[base+1][2:0];
         ren_newp   = stim[base+2][4:0];
         src_areg   = stim[base+3][2:0];
         ckpt_save  = stim[base+4][0];
         ckpt_free  = stim[base+5][0];
         restore    = stim[base+6][0];
         restore_id = stim[base+7][3:0];
         #5;  // Combinational outputs have settled, next rising edge is 5 away
         check_value("src_preg", line + 1, 8'(src_preg), stim[base+8]);
         check_value("old_preg", line + 1, 8'(old_preg), stim[base+9]);
         check_value("ckpt_id", line + 1, 8'(ckpt_id), stim[base+10]);
         check_value("ckpt_full", line + 1, 8'(ckpt_full), stim[base+11]);
      end

      $display("Test completed successfully");
      $finish;
   end

endmodule

// ==== rename_stimulus.txt ====
// ren_valid ren_dst ren_newp src_areg save free restore restore_id
//   then expected src_preg old_preg ckpt_id ckpt_full, all hex, one cycle per line
00 07 00 00 00 00 00 00  00 07 00 00
00 06 00 01 00 00 00 00  01 06 00 00
00 05 00 02 00 00 00 00  02 05 00 00
00 04 00 03 00 00 00 00  03 04 00 00
00 03 00 04 00 00 00 00  04 03 00 00
00 02 00 05 00 00 00 00  05 02 00 00
00 01 00 06 00 00 00 00  06 01 00 00
00 00 00 07 00 00 00 00  07 00 00 00
01 03 14 03 00 00 00 00  03 03 00 00
00 03 00 03 00 00 00 00  14 14 00 00
01 05 15 05 01 00 00 00  05 05 00 00
01 03 16 05 00 00 00 00  15 14 01 00
00 05 00 03 00 00 01 00  16 15 01 00
00 03 00 05 00 00 00 00  05 14 00 00
00 02 00 01 00 00 00 00  01 02 00 00
00 02 00 02 01 00 00 00  02 02 00 00
01 02 18 02 00 00 00 00  02 02 01 00
01 04 19 02 01 00 00 00  18 04 01 00
01 02 1a 04 00 00 00 00  19 18 02 00
00 04 00 02 00 00 01 00  1a 19 02 00
00 04 00 02 01 00 00 00  02 04 00 00
00 03 00 03 00 01 00 00  14 14 01 00
00 03 00 03 01 00 00 00  14 14 01 00
00 03 00 03 01 00 00 00  14 14 02 00
00 03 00 03 01 00 00 00  14 14 03 00
00 03 00 03 01 00 00 00  14 14 04 00
00 03 00 03 01 00 00 00  14 14 05 00
00 03 00 03 01 00 00 00  14 14 06 00
00 03 00 03 01 00 00 00  14 14 07 00
00 03 00 03 01 00 00 00  14 14 08 00
00 03 00 03 01 00 00 00  14 14 09 00
00 03 00 03 01 00 00 00  14 14 0a 00
00 03 00 03 01 00 00 00  14 14 0b 00
00 03 00 03 01 00 00 00  14 14 0c 00
00 03 00 03 01 00 00 00  14 14 0d 00
00 03 00 03 01 00 00 00  14 14 0e 00
00 03 00 03 01 00 00 00  14 14 0f 00
00 03 00 03 01 00 00 00  14 14 00 00
00 03 00 03 00 01 00 00  14 14 01 01
00 03 00 03 01 00 00 00  14 14 01 00
00 03 00 03 00 00 00 00  14 14 02 01

// ==== files.f ====
rename_pkg.sv
ckpt_pkg.sv
ckpt_if.sv
checkpoint_ram.sv
checkpoint_alloc.sv
rename_map.sv
rename_top.sv
tb_rename.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_rename
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
